/* common/loader_bus_pkg.sv */
`default_nettype none

package loader_bus_pkg;

   typedef logic [27:0] ddr_addr_t;      // DDR3 byte address
   typedef logic [26:0] ram_addr_t;      // RAM byte address
   typedef logic  [7:0] byte_t;
   typedef logic [10:0] region_units_t;  // Region size in blocks

   // DDR3 read request, held until ready
   typedef struct packed {
      logic      rd;
      ddr_addr_t addr;
   } ddr_rd_req_t;

   // Byte is valid while rd and ready are both high
   typedef struct packed {
      logic  ready;
      byte_t dout;
   } ddr_rd_rsp_t;

   // One byte per ce cycle
   typedef struct packed {
      logic      ce;
      ram_addr_t addr;
      byte_t     din;
   } ram_wr_t;

endpackage

`default_nettype wire

/* common/msx_map_pkg.sv */
`default_nettype none

package msx_map_pkg;
   import loader_bus_pkg::*;

   // Record kind, header byte 3 bits 7:4
   typedef enum logic [3:0] {
      CONFIG_NONE          = 4'd0,
      CONFIG_FDC           = 4'd1,
      CONFIG_SLOT_A        = 4'd2,
      CONFIG_SLOT_B        = 4'd3,
      CONFIG_SLOT_INTERNAL = 4'd4,
      CONFIG_KBD_LAYOUT    = 4'd5,
      CONFIG_CONFIG        = 4'd6
   } config_typ_t;

   typedef enum logic [7:0] {
      ROM_NONE = 8'd0,
      ROM_ROM  = 8'd1,
      ROM_RAM  = 8'd2
   } data_id_t;

   typedef enum logic [4:0] {
      MAPPER_UNUSED     = 5'd0,
      MAPPER_NONE       = 5'd1,
      MAPPER_RAM        = 5'd2,
      MAPPER_ASCII8     = 5'd3,
      MAPPER_ASCII16    = 5'd4,
      MAPPER_KONAMI     = 5'd5,
      MAPPER_KONAMI_SCC = 5'd6,
      MAPPER_OFFSET     = 5'd7
   } mapper_typ_t;

   typedef enum logic [3:0] {
      DEVICE_NONE = 4'd0,
      DEVICE_FDC  = 4'd1,
      DEVICE_OPL3 = 4'd2,
      DEVICE_RTC  = 4'd3
   } device_typ_t;

   typedef logic [5:0] slot_idx_t;      // Slot, subslot, block

   typedef struct packed {
      mapper_typ_t mapper;
      device_typ_t device;
      logic  [3:0] ref_ram;
      logic  [1:0] offset_ram;
   } slot_entry_t;

   typedef struct packed {
      ram_addr_t     addr;
      region_units_t size;
      logic          ro;
   } lookup_ram_t;

   typedef struct packed {
      logic [7:0] ram_size;
      logic [3:0] slot_expander_en;
      logic [1:0] msx_typ;
   } bios_config_t;

   localparam logic [23:0] CONFIG_MAGIC = "MSX";

endpackage

`default_nettype wire

/* verilog/ddr_read_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_read_arbiter
   import loader_bus_pkg::*;
(
   input  wire               clk,
   input  wire               arst_n,
   input  wire ddr_rd_req_t  seq_req,
   output ddr_rd_rsp_t       seq_rsp,
   input  wire ddr_rd_req_t  fill_req,
   output ddr_rd_rsp_t       fill_rsp,
   output ddr_rd_req_t       ddr_req,
   input  wire ddr_rd_rsp_t  ddr_rsp
);

   typedef enum logic [1:0] {
      GNT_NONE, GNT_SEQ, GNT_FILL
   } grant_t;

   grant_t grant_q;
   grant_t grant;

   always_comb begin
      grant = grant_q;
      if (grant_q == GNT_NONE) begin
         if (seq_req.rd) grant = GNT_SEQ;             // Sequencer first
         else if (fill_req.rd) grant = GNT_FILL;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) grant_q <= GNT_NONE;
      else if (ddr_req.rd & ddr_rsp.ready) grant_q <= GNT_NONE;
      else grant_q <= grant;
   end

   assign ddr_req  = (grant == GNT_SEQ) ? seq_req : (grant == GNT_FILL) ? fill_req : '0;
   assign seq_rsp  = (grant == GNT_SEQ) ? ddr_rsp : '0;
   assign fill_rsp = (grant == GNT_FILL) ? ddr_rsp : '0;

endmodule

`default_nettype wire

/* loader/slot_layout_table.sv */
`timescale 1ns/1ps
`default_nettype none

module slot_layout_table
   import msx_map_pkg::*;
(
   input  wire               clk,
   input  wire               arst_n,
   input  wire               clear,
   input  wire               we,
   input  wire slot_idx_t    idx,
   input  wire slot_entry_t  wdata,
   output slot_entry_t       rdata,
   input  wire slot_idx_t    ext_idx,
   output slot_entry_t       ext_entry
);

   slot_entry_t mem [64];
   slot_idx_t   clr_idx;           // Walks all 64 entries once per clear

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         clr_idx <= '0;
      end else if (clear) begin
         clr_idx <= clr_idx + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (clear) begin
         mem[clr_idx] <= '{
            mapper:     MAPPER_UNUSED,
            device:     DEVICE_NONE,
            ref_ram:    4'd0,
            offset_ram: 2'd0
         };
      end else if (we) begin
         mem[idx] <= wdata;
      end
   end

   // Sequencer alias lookup
   assign rdata     = mem[idx];
   assign ext_entry = mem[ext_idx];

endmodule

`default_nettype wire

/* loader/ram_fill.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_fill
   import loader_bus_pkg::*;
#(
   parameter int BLOCK_SHIFT = 14
) (
   input  wire               clk,
   input  wire               arst_n,
   input  wire               start,
   input  wire ram_addr_t    ram_base,
   input  wire ddr_addr_t    src,
   input  wire ram_addr_t    len,
   input  wire         [2:0] pattern,
   input  wire               copy,
   output logic              busy,
   output ddr_rd_req_t       ddr_req,
   input  wire ddr_rd_rsp_t  ddr_rsp,
   output ram_wr_t           ram_wr,
   input  wire               sdram_ready
);

   localparam int CNT_W = $bits(region_units_t) + BLOCK_SHIFT;   // Largest region in bytes

   logic [CNT_W-1:0] wr_cnt;       // Region offset of next write
   logic [CNT_W-1:0] rd_cnt;       // Bytes fetched so far
   logic [CNT_W-1:0] total_q;
   ram_addr_t        base_q;
   ddr_addr_t        src_q;
   logic       [2:0] pattern_q;
   logic             copy_q;
   logic             rd;
   logic             buf_valid;
   byte_t            buf_q;
   logic             wr_fire;
   logic       [8:0] p;
   byte_t            fill_byte;

   assign wr_fire = busy & (~copy_q | buf_valid) & sdram_ready;
   assign p       = wr_cnt[8:0];

   always_comb begin
      case (pattern_q)
         3'd0:    fill_byte = buf_q;
         3'd1:    fill_byte = 8'hFF;
         3'd2:    fill_byte = 8'h00;
         3'd3:    fill_byte = (p[8] == p[1]) ? 8'hFF : 8'h00;
         3'd4:    fill_byte = (p[8] != p[0]) ? 8'hFF : 8'h00;
         default: fill_byte = 8'hFF;
      endcase
   end

   assign ram_wr  = '{ce: wr_fire, addr: base_q + ram_addr_t'(wr_cnt), din: fill_byte};
   assign ddr_req = '{rd: rd, addr: src_q};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy      <= 1'b0;
         rd        <= 1'b0;
         buf_valid <= 1'b0;
         wr_cnt    <= '0;
         rd_cnt    <= '0;
         src_q     <= '0;
      end else if (start) begin
         busy      <= 1'b1;
         rd        <= copy;
         buf_valid <= 1'b0;
         wr_cnt    <= '0;
         rd_cnt    <= '0;
         src_q     <= src;
      end else if (busy) begin
         if (rd & ddr_rsp.ready) begin
            rd        <= 1'b0;
            buf_valid <= 1'b1;
            src_q     <= src_q + 1'b1;
            rd_cnt    <= rd_cnt + 1'b1;
         end else if (copy_q & (rd_cnt != total_q) & (~buf_valid | wr_fire)) begin
            rd <= 1'b1;                    // Next byte while this one is written
         end
         if (wr_fire) begin
            buf_valid <= 1'b0;
            wr_cnt    <= wr_cnt + 1'b1;
            if (wr_cnt == total_q - 1'b1) busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         base_q    <= ram_base;
         total_q   <= CNT_W'(len);
         pattern_q <= pattern;
         copy_q    <= copy;
      end
      if (rd && ddr_rsp.ready) buf_q <= ddr_rsp.dout;
   end

endmodule

`default_nettype wire

/* loader/config_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module config_sequencer
   import loader_bus_pkg::*, msx_map_pkg::*;
#(
   parameter int BLOCK_SHIFT = 14
) (
   input  wire               clk,
   input  wire               arst_n,
   input  wire               ioctl_download,
   input  wire        [15:0] ioctl_index,
   input  wire        [26:0] ioctl_addr,
   input  wire               reload,
   output ddr_rd_req_t       ddr_req,
   input  wire ddr_rd_rsp_t  ddr_rsp,
   output logic              fill_start,
   output ram_addr_t         fill_ram_base,
   output ddr_addr_t         fill_src,
   output ram_addr_t         fill_len,
   output logic        [2:0] fill_pattern,
   output logic              fill_copy,
   input  wire               fill_busy,
   output logic              tbl_clear,
   output logic              tbl_we,
   output slot_idx_t         tbl_idx,
   output slot_entry_t       tbl_wdata,
   input  wire slot_entry_t  tbl_rdata,
   output logic              reset_rq,
   output lookup_ram_t       lookup_ram [16],
   output bios_config_t      bios_config
);

   typedef enum logic [2:0] {
      ST_IDLE, ST_CLEAN, ST_HEAD, ST_CHECK, ST_FILL_WAIT, ST_STORE
   } state_t;

   state_t        state;
   logic   [26:0] img_size;
   logic          dl_last;
   logic          load_pend;      // Trigger seen while busy
   logic          rd;
   ddr_addr_t     rd_addr;        // Next header byte
   logic    [5:0] clr_cnt;
   logic    [3:0] byte_cnt;
   byte_t         hdr [16];
   ram_addr_t     ram_alloc;
   logic    [3:0] ref_ram;
   logic          has_data;
   logic    [1:0] blk;
   logic          blk_wr;         // Second half of a block step
   slot_entry_t   alias_q;

   logic          dl_fall;
   logic          trigger;
   logic          start_load;
   logic          rec_ok;
   config_typ_t   rec_typ;
   data_id_t      data_id;
   region_units_t units;
   ram_addr_t     len;
   logic          fill_go;
   logic    [1:0] m;
   logic    [1:0] pr;

   assign dl_fall    = dl_last & ~ioctl_download & (ioctl_index[5:0] == 6'd1);
   assign trigger    = dl_fall | reload;
   assign start_load = (state == ST_IDLE) & (trigger | load_pend);

   assign rec_ok  = {hdr[0], hdr[1], hdr[2]} == CONFIG_MAGIC;
   assign rec_typ = config_typ_t'(hdr[3][7:4]);
   assign data_id = data_id_t'(hdr[4]);
   assign units   = {hdr[5][2:0], hdr[6]};
   assign len     = ram_addr_t'(units) << BLOCK_SHIFT;
   assign fill_go = (state == ST_CHECK) & rec_ok & (rec_typ == CONFIG_SLOT_INTERNAL) &
                    (data_id == ROM_ROM | data_id == ROM_RAM) & (units != '0);

   assign m  = hdr[9][2*blk +: 2];
   assign pr = hdr[10][2*blk +: 2];

   assign reset_rq  = state != ST_IDLE;
   assign ddr_req   = '{rd: rd, addr: rd_addr};
   assign tbl_clear = state == ST_CLEAN;
   assign tbl_we    = (state == ST_STORE) & blk_wr & (m != 2'd0);
   assign tbl_idx   = {hdr[3][3:0], blk_wr ? blk : pr};   // Alias read, then write

   always_comb begin
      tbl_wdata.mapper     = (m == 2'd2) ? mapper_typ_t'(hdr[8][4:0]) : MAPPER_UNUSED;
      tbl_wdata.device     = device_typ_t'(hdr[7][3:0]);
      tbl_wdata.ref_ram    = (data_id == ROM_NONE) ? 4'd0 : ref_ram;
      tbl_wdata.offset_ram = pr;
      if (m == 2'd1) begin
         tbl_wdata        = alias_q;
         tbl_wdata.device = DEVICE_NONE;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state       <= ST_IDLE;
         img_size    <= '0;
         dl_last     <= 1'b0;
         load_pend   <= 1'b0;
         rd          <= 1'b0;
         rd_addr     <= '0;
         clr_cnt     <= '0;
         byte_cnt    <= '0;
         ram_alloc   <= '0;
         ref_ram     <= '0;
         has_data    <= 1'b0;
         blk         <= '0;
         blk_wr      <= 1'b0;
         fill_start  <= 1'b0;
         bios_config <= '0;
      end else begin
         dl_last    <= ioctl_download;
         fill_start <= fill_go;
         if (dl_fall) img_size <= ioctl_addr;
         if (trigger & state != ST_IDLE) load_pend <= 1'b1;
         case (state)
            ST_IDLE: begin
               if (start_load) begin
                  state       <= ST_CLEAN;
                  load_pend   <= 1'b0;
                  clr_cnt     <= '0;
                  rd_addr     <= '0;
                  byte_cnt    <= '0;
                  ram_alloc   <= '0;
                  ref_ram     <= '0;
                  bios_config <= '0;
               end
            end
            ST_CLEAN: begin
               clr_cnt <= clr_cnt + 1'b1;
               if (clr_cnt == 6'd63) state <= ST_HEAD;
            end
            ST_HEAD: begin
               if (!rd) begin
                  if (byte_cnt == '0 && rd_addr >= ddr_addr_t'(img_size)) state <= ST_IDLE;
                  else rd <= 1'b1;
               end else if (ddr_rsp.ready) begin
                  rd       <= 1'b0;
                  rd_addr  <= rd_addr + 1'b1;
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt == 4'd15) state <= ST_CHECK;
               end
            end
            ST_CHECK: begin
               state    <= ST_HEAD;
               blk      <= '0;
               blk_wr   <= 1'b0;
               has_data <= fill_go;
               if (!rec_ok) begin
                  state <= ST_IDLE;
               end else if (rec_typ == CONFIG_CONFIG) begin
                  bios_config.slot_expander_en <= hdr[4][3:0];
                  bios_config.msx_typ          <= hdr[4][5:4];
               end else if (rec_typ == CONFIG_SLOT_INTERNAL) begin
                  state <= fill_go ? ST_FILL_WAIT : ST_STORE;
                  if (data_id == ROM_RAM && hdr[6] > bios_config.ram_size)
                     bios_config.ram_size <= hdr[6];
                  if (fill_go) ram_alloc <= ram_alloc + len;
                  if (fill_go && data_id == ROM_ROM) rd_addr <= rd_addr + ddr_addr_t'(len);
               end
            end
            ST_FILL_WAIT: begin
               if (!fill_busy && !fill_start) state <= ST_STORE;   // Busy rises after start
            end
            ST_STORE: begin
               blk_wr <= ~blk_wr;
               if (blk_wr) begin
                  blk <= blk + 1'b1;
                  if (blk == 2'd3) begin
                     state   <= ST_HEAD;
                     ref_ram <= ref_ram + 4'(has_data);
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_HEAD && rd && ddr_rsp.ready) hdr[byte_cnt] <= ddr_rsp.dout;
      if (state == ST_STORE && !blk_wr) alias_q <= tbl_rdata;   // Blocks stored in order 0..3
      if (state == ST_CHECK) begin
         fill_ram_base <= ram_alloc;
         fill_src      <= rd_addr;
         fill_len      <= len;
         fill_pattern  <= (data_id == ROM_ROM) ? 3'd0 : hdr[11][2:0];
         fill_copy     <= data_id == ROM_ROM;
      end
      if (fill_go) lookup_ram[ref_ram] <= '{addr: ram_alloc, size: units, ro: data_id == ROM_ROM};
   end

endmodule

`default_nettype wire

/* loader/memory_upload.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_upload
   import loader_bus_pkg::*, msx_map_pkg::*;
#(
   parameter int BLOCK_SHIFT = 14
) (
   input  wire               clk,
   input  wire               arst_n,
   input  wire               ioctl_download,
   input  wire        [15:0] ioctl_index,
   input  wire        [26:0] ioctl_addr,
   input  wire               reload,
   output ddr_rd_req_t       ddr_req,
   input  wire ddr_rd_rsp_t  ddr_rsp,
   output ram_wr_t           ram_wr,
   input  wire               sdram_ready,
   output logic              reset_rq,
   input  wire slot_idx_t    layout_idx,
   output slot_entry_t       layout_entry,
   output lookup_ram_t       lookup_ram [16],
   output bios_config_t      bios_config
);

   ddr_rd_req_t   seq_req;
   ddr_rd_rsp_t   seq_rsp;
   ddr_rd_req_t   fill_req;
   ddr_rd_rsp_t   fill_rsp;

   logic          fill_start;
   ram_addr_t     fill_ram_base;
   ddr_addr_t     fill_src;
   ram_addr_t     fill_len;
   logic    [2:0] fill_pattern;
   logic          fill_copy;
   logic          fill_busy;

   logic          tbl_clear;
   logic          tbl_we;
   slot_idx_t     tbl_idx;
   slot_entry_t   tbl_wdata;
   slot_entry_t   tbl_rdata;

   config_sequencer #(
      .BLOCK_SHIFT (BLOCK_SHIFT)
   ) i_config_sequencer (
      .clk            (clk),
      .arst_n         (arst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .reload         (reload),
      .ddr_req        (seq_req),
      .ddr_rsp        (seq_rsp),
      .fill_start     (fill_start),
      .fill_ram_base  (fill_ram_base),
      .fill_src       (fill_src),
      .fill_len       (fill_len),
      .fill_pattern   (fill_pattern),
      .fill_copy      (fill_copy),
      .fill_busy      (fill_busy),
      .tbl_clear      (tbl_clear),
      .tbl_we         (tbl_we),
      .tbl_idx        (tbl_idx),
      .tbl_wdata      (tbl_wdata),
      .tbl_rdata      (tbl_rdata),
      .reset_rq       (reset_rq),
      .lookup_ram     (lookup_ram),
      .bios_config    (bios_config)
   );

   ram_fill #(
      .BLOCK_SHIFT (BLOCK_SHIFT)
   ) i_ram_fill (
      .clk         (clk),
      .arst_n      (arst_n),
      .start       (fill_start),
      .ram_base    (fill_ram_base),
      .src         (fill_src),
      .len         (fill_len),
      .pattern     (fill_pattern),
      .copy        (fill_copy),
      .busy        (fill_busy),
      .ddr_req     (fill_req),
      .ddr_rsp     (fill_rsp),
      .ram_wr      (ram_wr),
      .sdram_ready (sdram_ready)
   );

   ddr_read_arbiter i_ddr_read_arbiter (
      .clk      (clk),
      .arst_n   (arst_n),
      .seq_req  (seq_req),
      .seq_rsp  (seq_rsp),
      .fill_req (fill_req),
      .fill_rsp (fill_rsp),
      .ddr_req  (ddr_req),
      .ddr_rsp  (ddr_rsp)
   );

   slot_layout_table i_slot_layout_table (
      .clk       (clk),
      .arst_n    (arst_n),
      .clear     (tbl_clear),
      .we        (tbl_we),
      .idx       (tbl_idx),
      .wdata     (tbl_wdata),
      .rdata     (tbl_rdata),
      .ext_idx   (layout_idx),
      .ext_entry (layout_entry)
   );

endmodule

`default_nettype wire

/* verif/tb_image_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_image_builder
   import loader_bus_pkg::*;
#(
   parameter int BLOCK_SHIFT = 14
) (
   input  wire               clk,
   input  wire ddr_rd_req_t  ddr_req,
   output ddr_rd_rsp_t       ddr_rsp,
   input  wire ram_wr_t      ram_wr,
   output logic              sdram_ready
);

   localparam int MEM_BYTES = 4096;

   byte_t       ddr_mem [MEM_BYTES];
   byte_t       ram_mem [MEM_BYTES];
   int          wr_ptr      = 0;      // Next free byte of the image
   int          proto_errs  = 0;
   logic        stall_en    = 1'b0;
   logic        ddr_ready   = 1'b1;
   logic        sdram_rdy_q = 1'b1;
   logic [15:0] lfsr        = 16'd33;
   logic        prev_rd     = 1'b0;
   logic        prev_ready  = 1'b0;
   ddr_addr_t   prev_addr   = '0;

   assign ddr_rsp     = '{ready: ddr_ready, dout: ddr_mem[ddr_req.addr[11:0]]};
   assign sdram_ready = sdram_rdy_q;

   function automatic logic [15:0] next_lfsr(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per bit
   function automatic logic [15:0] draw_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[14:0], lfsr[0]};
         lfsr = next_lfsr(lfsr);
      end
      return v;
   endfunction

   task automatic set_stalls(input logic en);
      stall_en = en;
   endtask

   task automatic clear_image();
      for (int a = 0; a < MEM_BYTES; a++) ddr_mem[a] = 8'h00;
      wr_ptr = 0;
   endtask

   task automatic init_ram();
      for (int a = 0; a < MEM_BYTES; a++) ram_mem[a] = byte_t'(a ^ (a >> 4) ^ (a >> 8)) ^ 8'hA5;
   endtask

   // Magic, type and slot; the rest random
   task automatic put_header(input logic [3:0] typ, input logic [3:0] slot);
      ddr_mem[wr_ptr]     = "M";
      ddr_mem[wr_ptr + 1] = "S";
      ddr_mem[wr_ptr + 2] = "X";
      ddr_mem[wr_ptr + 3] = {typ, slot};
      for (int i = 4; i < 16; i++) ddr_mem[wr_ptr + i] = 8'(draw_bits(8));
   endtask

   task automatic add_slot(input logic [3:0] slot, input byte_t id, input logic [10:0] units,
                           input logic [3:0] device, input logic [4:0] mapper,
                           input byte_t mode, input byte_t param, input logic [2:0] pattern);
      int len;
      len = int'(units) << BLOCK_SHIFT;
      put_header(4'd4, slot);
      ddr_mem[wr_ptr + 4]  = id;
      ddr_mem[wr_ptr + 5]  = {5'(draw_bits(5)), units[10:8]};
      ddr_mem[wr_ptr + 6]  = units[7:0];
      ddr_mem[wr_ptr + 7]  = {4'(draw_bits(4)), device};
      ddr_mem[wr_ptr + 8]  = {3'(draw_bits(3)), mapper};
      ddr_mem[wr_ptr + 9]  = mode;
      ddr_mem[wr_ptr + 10] = param;
      ddr_mem[wr_ptr + 11] = {5'(draw_bits(5)), pattern};
      wr_ptr += 16;
      if (id == 8'd1) begin
         for (int i = 0; i < len; i++) ddr_mem[wr_ptr + i] = 8'(draw_bits(8));
         wr_ptr += len;                                     // ROM data follows header
      end
   endtask

   task automatic add_config(input logic [3:0] expander, input logic [1:0] msx_typ);
      put_header(4'd6, 4'd0);
      ddr_mem[wr_ptr + 4] = {2'(draw_bits(2)), msx_typ, expander};
      wr_ptr += 16;
   endtask

   task automatic add_bad();
      put_header(4'd4, 4'd0);
      ddr_mem[wr_ptr + 2] = "Y";
      wr_ptr += 16;
   endtask

   always @(posedge clk) begin
      #1;
      if (stall_en) begin
         ddr_ready   = draw_bits(1) == 16'd1;
         sdram_rdy_q = draw_bits(1) == 16'd1;
      end else begin
         ddr_ready   = 1'b1;
         sdram_rdy_q = 1'b1;
      end
   end

   // RAM model and bus protocol monitor
   always @(posedge clk) begin
      if (ram_wr.ce) begin
         if (!sdram_rdy_q) begin
            $display("RAM write issued while sdram_ready was low, address %0d", ram_wr.addr);
            proto_errs++;
         end
         if (ram_wr.addr[26:12] != '0) begin
            $display("RAM write outside the modeled memory, address %0d", ram_wr.addr);
            proto_errs++;
         end else begin
            ram_mem[ram_wr.addr[11:0]] = ram_wr.din;
         end
      end
      if (ddr_req.rd && ddr_req.addr[27:12] != '0) begin
         $display("DDR3 read outside the image, address %0d", ddr_req.addr);
         proto_errs++;
      end
      if (prev_rd && !prev_ready && (!ddr_req.rd || ddr_req.addr != prev_addr)) begin
         $display("DDR3 read dropped or moved before ready, address %0d", prev_addr);
         proto_errs++;
      end
      if (prev_rd && prev_ready && ddr_req.rd) begin
         $display("DDR3 read not released for a cycle after ready, address %0d", prev_addr);
         proto_errs++;
      end
      prev_rd    = ddr_req.rd;
      prev_ready = ddr_ready;
      prev_addr  = ddr_req.addr;
   end

endmodule

`default_nettype wire

/* verif/tb_memory_upload.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_memory_upload
   import loader_bus_pkg::*, msx_map_pkg::*;
();

   localparam int BLOCK_SHIFT = 6;
   localparam int RAM_BYTES   = 4096;
   localparam int CYCLE_LIMIT = 200_000;   // Four loads of under 10k cycles each

   logic         clk = 1'b0;
   logic         arst_n;
   logic         ioctl_download;
   logic  [15:0] ioctl_index;
   logic  [26:0] ioctl_addr;
   logic         reload;
   logic         sdram_ready;
   slot_idx_t    layout_idx;
   ddr_rd_req_t  ddr_req;
   ddr_rd_rsp_t  ddr_rsp;
   ram_wr_t      ram_wr;
   logic         reset_rq;
   slot_entry_t  layout_entry;
   lookup_ram_t  lookup_ram [16];
   bios_config_t bios_config;

   byte_t        exp_ram [RAM_BYTES];
   slot_entry_t  exp_layout [64];
   lookup_ram_t  exp_lookup [16];
   logic  [15:0] exp_lookup_set;          // Entries written by this load
   bios_config_t exp_bios;
   int           err_cnt   = 0;
   int           cycle_cnt = 0;
   int           img_size;

   memory_upload #(
      .BLOCK_SHIFT (BLOCK_SHIFT)
   ) i_memory_upload (
      .clk            (clk),
      .arst_n         (arst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .reload         (reload),
      .ddr_req        (ddr_req),
      .ddr_rsp        (ddr_rsp),
      .ram_wr         (ram_wr),
      .sdram_ready    (sdram_ready),
      .reset_rq       (reset_rq),
      .layout_idx     (layout_idx),
      .layout_entry   (layout_entry),
      .lookup_ram     (lookup_ram),
      .bios_config    (bios_config)
   );

   tb_image_builder #(
      .BLOCK_SHIFT (BLOCK_SHIFT)
   ) i_image_builder (
      .clk         (clk),
      .ddr_req     (ddr_req),
      .ddr_rsp     (ddr_rsp),
      .ram_wr      (ram_wr),
      .sdram_ready (sdram_ready)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the load never finished", CYCLE_LIMIT);
         $display("Errors: %0d value, %0d protocol", err_cnt, i_image_builder.proto_errs);
         $display("Simulation FAILED");
         $finish;
      end
   end

   function automatic byte_t pattern_byte(input logic [2:0] pat, input int unsigned off);
      logic [8:0] p;
      p = off[8:0];                        // Offset modulo 512
      case (pat)
         3'd2:    return 8'h00;
         3'd3:    return (p[8] == p[1]) ? 8'hFF : 8'h00;
         3'd4:    return (p[8] != p[0]) ? 8'hFF : 8'h00;
         default: return 8'hFF;
      endcase
   endfunction

   // Walks the image as the loader should and fills the expected tables
   function automatic bios_config_t predict_load(input int size);
      byte_t        h [16];
      int           addr;
      int           alloc;
      int           len;
      logic  [10:0] units;
      logic   [3:0] slot;
      logic   [3:0] ref_idx;
      logic   [1:0] m;
      logic   [1:0] pr;
      logic         has_data;
      slot_entry_t  e;
      bios_config_t bios;
      bios           = '0;
      addr           = 0;
      alloc          = 0;
      ref_idx        = '0;
      exp_lookup_set = '0;
      for (int a = 0; a < RAM_BYTES; a++) exp_ram[a] = i_image_builder.ram_mem[a];
      for (int i = 0; i < 64; i++) exp_layout[i] = '0;
      while (addr < size) begin
         for (int i = 0; i < 16; i++) h[i] = i_image_builder.ddr_mem[addr + i];
         if ({h[0], h[1], h[2]} != CONFIG_MAGIC) break;
         addr += 16;
         slot = h[3][3:0];
         if (h[3][7:4] == 4'd6) begin
            bios.slot_expander_en = h[4][3:0];
            bios.msx_typ          = h[4][5:4];
         end else if (h[3][7:4] == 4'd4) begin
            units    = {h[5][2:0], h[6]};
            len      = int'(units) << BLOCK_SHIFT;
            has_data = (h[4] == 8'd1 || h[4] == 8'd2) && units != '0;
            if (h[4] == 8'd2 && h[6] > bios.ram_size) bios.ram_size = h[6];
            if (has_data) begin
               for (int i = 0; i < len; i++) begin
                  if (h[4] == 8'd1) exp_ram[alloc + i] = i_image_builder.ddr_mem[addr + i];
                  else exp_ram[alloc + i] = pattern_byte(h[11][2:0], i);
               end
               exp_lookup[ref_idx]     = '{addr: ram_addr_t'(alloc), size: units,
                                           ro: h[4] == 8'd1};
               exp_lookup_set[ref_idx] = 1'b1;
               alloc += len;
               if (h[4] == 8'd1) addr += len;
            end
            for (int b = 0; b < 4; b++) begin
               m  = h[9][2*b +: 2];
               pr = h[10][2*b +: 2];
               e  = exp_layout[{slot, 2'(b)}];
               case (m)
                  2'd1: begin
                     e        = exp_layout[{slot, pr}];
                     e.device = DEVICE_NONE;
                  end
                  2'd2: e = '{mapper: mapper_typ_t'(h[8][4:0]), device: device_typ_t'(h[7][3:0]),
                              ref_ram: (h[4] == 8'd0) ? 4'd0 : ref_idx, offset_ram: pr};
                  2'd3: e = '{mapper: MAPPER_UNUSED, device: device_typ_t'(h[7][3:0]),
                              ref_ram: (h[4] == 8'd0) ? 4'd0 : ref_idx, offset_ram: pr};
                  default: ;
               endcase
               exp_layout[{slot, 2'(b)}] = e;
            end
            if (has_data) ref_idx++;
         end
      end
      return bios;
   endfunction

   task automatic compare_results(input string name);
      for (int a = 0; a < RAM_BYTES; a++) begin
         if (i_image_builder.ram_mem[a] !== exp_ram[a]) begin
            $display("ERR %s ram[%0d]: expected %h, actual %h", name, a, exp_ram[a],
                     i_image_builder.ram_mem[a]);
            err_cnt++;
         end
      end
      for (int i = 0; i < 16; i++) begin
         if (exp_lookup_set[i] && lookup_ram[i] !== exp_lookup[i]) begin
            $display("ERR %s lookup[%0d]: expected %h, actual %h", name, i, exp_lookup[i],
                     lookup_ram[i]);
            err_cnt++;
         end
      end
      if (bios_config !== exp_bios) begin
         $display("ERR %s bios_config: expected %h, actual %h", name, exp_bios, bios_config);
         err_cnt++;
      end
      for (int i = 0; i < 64; i++) begin
         @(posedge clk);
         #1 layout_idx = slot_idx_t'(i);
         @(negedge clk);
         if (layout_entry !== exp_layout[i]) begin
            $display("ERR %s layout[%0d]: expected %h, actual %h", name, i, exp_layout[i],
                     layout_entry);
            err_cnt++;
         end
      end
   endtask

   task automatic check_idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         if (reset_rq || ddr_req.rd || ram_wr.ce) begin
            $display("ERR idle: expected rq/rd/ce 000, actual %b%b%b", reset_rq, ddr_req.rd,
                     ram_wr.ce);
            err_cnt++;
         end
      end
   endtask

   task automatic wait_load_done();
      while (!reset_rq) @(negedge clk);
      while (reset_rq) @(negedge clk);     // Idle again, reset_rq low
   endtask

   task automatic run_download(input string name, input int size);
      i_image_builder.init_ram();
      exp_bios = predict_load(size);
      @(posedge clk);
      #1;
      ioctl_addr     = 27'(size);
      ioctl_index    = 16'd1;
      ioctl_download = 1'b1;
      repeat (4) @(posedge clk);
      #1 ioctl_download = 1'b0;
      wait_load_done();
      compare_results(name);
   endtask

   task automatic build_main_image();
      i_image_builder.clear_image();
      i_image_builder.add_slot(4'h0, ROM_ROM, 11'd2, DEVICE_NONE, MAPPER_ASCII16,
                               8'b00_01_10_10, 8'b00_00_01_00, 3'd0);   // Block 2 aliases 0
      i_image_builder.add_slot(4'hC, ROM_RAM, 11'd3, DEVICE_NONE, MAPPER_RAM,
                               8'hAA, 8'hE4, 3'd1);
      i_image_builder.add_slot(4'hD, ROM_RAM, 11'd9, DEVICE_NONE, MAPPER_RAM,
                               8'b11_00_10_10, 8'b00_00_01_00, 3'd3);
      i_image_builder.add_slot(4'hE, ROM_RAM, 11'd8, DEVICE_NONE, MAPPER_RAM,
                               8'hAA, 8'h1B, 3'd4);
      i_image_builder.add_slot(4'hF, ROM_RAM, 11'd1, DEVICE_NONE, MAPPER_RAM,
                               8'h0A, 8'h04, 3'd2);
      i_image_builder.add_slot(4'hB, ROM_RAM, 11'd1, DEVICE_NONE, MAPPER_RAM,
                               8'h02, 8'h00, 3'd6);
      i_image_builder.add_slot(4'h4, ROM_NONE, 11'd0, DEVICE_FDC, MAPPER_NONE,
                               8'b00_10_11_11, 8'b00_10_01_00, 3'd0);
      i_image_builder.add_slot(4'h1, ROM_ROM, 11'd1, DEVICE_OPL3, MAPPER_KONAMI,
                               8'b01_01_00_10, 8'h00, 3'd0);
      i_image_builder.add_config(4'b1001, 2'd2);
      i_image_builder.add_bad();
      i_image_builder.add_config(4'b1111, 2'd3);                        // Past the bad magic
      img_size = i_image_builder.wr_ptr;
   endtask

   initial begin
      arst_n         = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index    = '0;
      ioctl_addr     = '0;
      reload         = 1'b0;
      layout_idx     = '0;
      repeat (16) @(posedge clk);
      #1 arst_n = 1'b1;
      check_idle(20);

      build_main_image();
      run_download("main_image", img_size);

      i_image_builder.clear_image();
      i_image_builder.add_config(4'b0110, 2'd1);
      i_image_builder.add_slot(4'h8, ROM_NONE, 11'd0, DEVICE_RTC, MAPPER_OFFSET,
                               8'b11_10_01_00, 8'b01_00_00_00, 3'd0);
      img_size = i_image_builder.wr_ptr;
      i_image_builder.add_config(4'b1111, 2'd3);                        // Beyond the image size
      run_download("end_of_image", img_size);

      i_image_builder.set_stalls(1'b1);
      build_main_image();
      run_download("stalled", img_size);

      i_image_builder.init_ram();
      exp_bios = predict_load(img_size);
      @(posedge clk);
      #1 reload = 1'b1;
      @(posedge clk);
      #1 reload = 1'b0;
      wait_load_done();
      compare_results("stalled_reload");

      $display("Errors: %0d value, %0d protocol", err_cnt, i_image_builder.proto_errs);
      if (err_cnt == 0 && i_image_builder.proto_errs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
common/loader_bus_pkg.sv
common/msx_map_pkg.sv
verilog/ddr_read_arbiter.sv
loader/slot_layout_table.sv
loader/ram_fill.sv
loader/config_sequencer.sv
loader/memory_upload.sv
verif/tb_image_builder.sv
verif/tb_memory_upload.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory upload testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_memory_upload -f filelist.f -o tb_memory_upload

out=$(./obj_dir/tb_memory_upload)
echo "$out"

if echo "$out" | grep -qx "Simulation PASSED"; then
   exit 0
fi
exit 1
